/* src/exec_pkg.sv */
package exec_pkg;

    // =========================================================================
    // Widths
    // =========================================================================

    // Data and address width
    localparam int XLEN      = 32;
    // Reorder-buffer index width
    localparam int ROB_IDX_W = 5;
    // Physical register tag width
    localparam int PR_W      = 6;

    // =========================================================================
    // Opcodes and select encodings
    // =========================================================================

    // ALU operations
    typedef enum logic [3:0] {
        ADD, SUB, AND, OR, XOR, SLT, SLTU, SLL, SRL, SRA
    } alu_op_e;

    // ALU operand A source
    typedef enum logic [1:0] {
        OPA_RS1, OPA_PC, OPA_NPC, OPA_ZERO
    } opa_sel_e;

    // ALU operand B source
    typedef enum logic {
        OPB_RS2, OPB_IMM
    } opb_sel_e;

    // Branch unit operations with jumps last
    typedef enum logic [2:0] {
        BEQ, BNE, BLT, BGE, BLTU, BGEU, JAL, JALR
    } br_op_e;

    // Issue port handshake state shared by both units
    typedef enum logic {
        IDLE, ACKED
    } hs_state_e;

    // =========================================================================
    // Packets
    // =========================================================================

    // ALU issue packet with operands already read
    typedef struct packed {
        logic [ROB_IDX_W-1:0] rob_idx;
        logic [PR_W-1:0]      dest_pr;
        logic [XLEN-1:0]      pc;
        logic [XLEN-1:0]      rs1;
        logic [XLEN-1:0]      rs2;
        logic [XLEN-1:0]      imm;
        alu_op_e              func;
        opa_sel_e             opa_sel;
        opb_sel_e             opb_sel;
    } alu_issue_t;

    // Branch issue packet that carries the prediction
    typedef struct packed {
        logic [ROB_IDX_W-1:0] rob_idx;
        logic [PR_W-1:0]      dest_pr;
        logic [XLEN-1:0]      pc;
        logic [XLEN-1:0]      rs1;
        logic [XLEN-1:0]      rs2;
        logic [XLEN-1:0]      offset;
        br_op_e               func;
        logic                 pred_taken;
    } br_issue_t;

    // Completion packet to the reorder buffer
    typedef struct packed {
        logic [ROB_IDX_W-1:0] rob_idx;
        logic [PR_W-1:0]      dest_pr;
        logic                 write_valid;
        logic [XLEN-1:0]      result;
        logic                 branch_valid;
        logic                 branch_taken;
        logic [XLEN-1:0]      branch_target;
        logic                 mispredict;
    } complete_t;

endpackage

/* src/alu_unit.sv */
`timescale 1ns/100ps

module alu_unit (
    input  logic                 clock,
    input  logic                 arst_n,
    input  logic                 alu_req,
    input  exec_pkg::alu_issue_t alu_pkt,
    output logic                 alu_ack,
    input  logic                 alu_take,
    output logic                 alu_full,
    output exec_pkg::complete_t  alu_res
);

    exec_pkg::hs_state_e       state;
    logic [exec_pkg::XLEN-1:0] opa;
    logic [exec_pkg::XLEN-1:0] opb;
    logic [4:0]                shamt;
    logic [exec_pkg::XLEN-1:0] result;
    exec_pkg::complete_t       res_next;
    logic                      slot_we;

    // =========================================================================
    // Operand selection and arithmetic
    // =========================================================================

    always_comb begin
        // Operand A
        case (alu_pkt.opa_sel)
            exec_pkg::OPA_RS1: opa = alu_pkt.rs1;
            exec_pkg::OPA_PC:  opa = alu_pkt.pc;
            exec_pkg::OPA_NPC: opa = alu_pkt.pc + exec_pkg::XLEN'(4);
            default:           opa = '0;
        endcase
        // Operand B
        opb = (alu_pkt.opb_sel == exec_pkg::OPB_IMM) ? alu_pkt.imm : alu_pkt.rs2;
    end

    // Shifts use only the low five bits
    assign shamt = opb[4:0];

    always_comb begin
        case (alu_pkt.func)
            exec_pkg::ADD:  result = opa + opb;
            exec_pkg::SUB:  result = opa - opb;
            exec_pkg::AND:  result = opa & opb;
            exec_pkg::OR:   result = opa | opb;
            exec_pkg::XOR:  result = opa ^ opb;
            // Set-less-than gives 0 or 1
            exec_pkg::SLT:  result = {{(exec_pkg::XLEN-1){1'b0}}, $signed(opa) < $signed(opb)};
            exec_pkg::SLTU: result = {{(exec_pkg::XLEN-1){1'b0}}, opa < opb};
            exec_pkg::SLL:  result = opa << shamt;
            exec_pkg::SRL:  result = opa >> shamt;
            exec_pkg::SRA:  result = $signed(opa) >>> shamt;
            default:        result = '0;
        endcase
    end

    // Completion packet without branch information from the ALU
    always_comb begin
        res_next               = '0;
        res_next.rob_idx       = alu_pkt.rob_idx;
        res_next.dest_pr       = alu_pkt.dest_pr;
        res_next.write_valid   = (alu_pkt.dest_pr != '0);
        res_next.result        = result;
    end

    // =========================================================================
    // Issue handshake and result slot
    // =========================================================================

    // Capture only from idle with an empty slot
    assign slot_we = (state == exec_pkg::IDLE) && alu_req && !alu_full;
    assign alu_ack = (state == exec_pkg::ACKED);

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state    <= exec_pkg::IDLE;
            alu_full <= 1'b0;
        end else begin
            if (slot_we) begin
                state <= exec_pkg::ACKED;
            end else if (state == exec_pkg::ACKED && !alu_req) begin
                // Issuer has dropped req, release ack
                state <= exec_pkg::IDLE;
            end
            // Take and capture never coincide
            if (slot_we) begin
                alu_full <= 1'b1;
            end else if (alu_take) begin
                alu_full <= 1'b0;
            end
        end
    end

    // Result payload
    always_ff @(posedge clock) begin
        if (slot_we) begin
            alu_res <= res_next;
        end
    end

    // Held result is never overwritten
    assert property (@(posedge clock) disable iff (!arst_n) alu_full |=> $stable(alu_res));

endmodule

/* src/branch_unit.sv */
`timescale 1ns/100ps

module branch_unit (
    input  logic                clock,
    input  logic                arst_n,
    input  logic                br_req,
    input  exec_pkg::br_issue_t br_pkt,
    output logic                br_ack,
    input  logic                br_take,
    output logic                br_full,
    output exec_pkg::complete_t br_res
);

    exec_pkg::hs_state_e       state;
    logic                      taken;
    logic                      is_jump;
    logic [exec_pkg::XLEN-1:0] target;
    exec_pkg::complete_t       res_next;
    logic                      slot_we;

    // =========================================================================
    // Condition, target and link value
    // =========================================================================

    always_comb begin
        case (br_pkt.func)
            exec_pkg::BEQ:  taken = (br_pkt.rs1 == br_pkt.rs2);
            exec_pkg::BNE:  taken = (br_pkt.rs1 != br_pkt.rs2);
            exec_pkg::BLT:  taken = ($signed(br_pkt.rs1) < $signed(br_pkt.rs2));
            exec_pkg::BGE:  taken = ($signed(br_pkt.rs1) >= $signed(br_pkt.rs2));
            exec_pkg::BLTU: taken = (br_pkt.rs1 < br_pkt.rs2);
            exec_pkg::BGEU: taken = (br_pkt.rs1 >= br_pkt.rs2);
            // Jumps always go
            default:        taken = 1'b1;
        endcase
    end

    assign is_jump = (br_pkt.func == exec_pkg::JAL) || (br_pkt.func == exec_pkg::JALR);

    // JALR is register relative with bit 0 cleared
    always_comb begin
        if (br_pkt.func == exec_pkg::JALR) begin
            target = (br_pkt.rs1 + br_pkt.offset) & ~exec_pkg::XLEN'(1);
        end else begin
            target = br_pkt.pc + br_pkt.offset;
        end
    end

    always_comb begin
        res_next.rob_idx       = br_pkt.rob_idx;
        res_next.dest_pr       = br_pkt.dest_pr;
        // Only jumps write the link register
        res_next.write_valid   = is_jump && (br_pkt.dest_pr != '0);
        res_next.result        = br_pkt.pc + exec_pkg::XLEN'(4);
        res_next.branch_valid  = 1'b1;
        res_next.branch_taken  = taken;
        res_next.branch_target = target;
        res_next.mispredict    = (taken != br_pkt.pred_taken);
    end

    // =========================================================================
    // Issue handshake and result slot
    // =========================================================================

    assign slot_we = (state == exec_pkg::IDLE) && br_req && !br_full;
    assign br_ack  = (state == exec_pkg::ACKED);

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state   <= exec_pkg::IDLE;
            br_full <= 1'b0;
        end else begin
            if (slot_we) begin
                state <= exec_pkg::ACKED;
            end else if (state == exec_pkg::ACKED && !br_req) begin
                state <= exec_pkg::IDLE;
            end
            // Slot fills on capture, drains on the merger's take
            if (slot_we) begin
                br_full <= 1'b1;
            end else if (br_take) begin
                br_full <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (slot_we) begin
            br_res <= res_next;
        end
    end

    // A rising ack always answers a req seen on the edge before
    assert property (@(posedge clock) disable iff (!arst_n) $rose(br_ack) |-> $past(br_req));

endmodule

/* src/complete_merge.sv */
`timescale 1ns/100ps

module complete_merge (
    input  logic                clock,
    input  logic                arst_n,
    input  logic                alu_full,
    input  exec_pkg::complete_t alu_res,
    input  logic                br_full,
    input  exec_pkg::complete_t br_res,
    output logic                alu_take,
    output logic                br_take,
    output logic                complete_req,
    output exec_pkg::complete_t complete_pkt,
    input  logic                complete_ack
);

    // Completion port handshake
    typedef enum logic [1:0] {
        IDLE,
        REQ,
        WAIT_LOW
    } merge_state_e;

    merge_state_e state;
    logic         idle;

    // =========================================================================
    // Fixed-priority pick
    // =========================================================================

    assign idle = (state == IDLE);

    // Branch first and ALU only when no branch is waiting
    assign br_take  = idle && br_full;
    assign alu_take = idle && alu_full && !br_full;

    // =========================================================================
    // Completion handshake FSM
    // =========================================================================

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (br_take || alu_take) begin
                        state <= REQ;
                    end
                end
                REQ: begin
                    // ROB has the packet and req drops
                    if (complete_ack) begin
                        state <= WAIT_LOW;
                    end
                end
                WAIT_LOW: begin
                    if (!complete_ack) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    assign complete_req = (state == REQ);

    // Packet loads only on a take and holds through the whole handshake
    always_ff @(posedge clock) begin
        if (br_take) begin
            complete_pkt <= br_res;
        end else if (alu_take) begin
            complete_pkt <= alu_res;
        end
    end

    // Waiting packet does not move under back-pressure
    assert property (@(posedge clock) disable iff (!arst_n)
        (complete_req && !complete_ack) |=> $stable(complete_pkt));

endmodule

/* src/exec_stage.sv */
`timescale 1ns/100ps

module exec_stage (
    input  logic                 clock,
    input  logic                 arst_n,
    // ALU issue port
    input  logic                 alu_req,
    input  exec_pkg::alu_issue_t alu_pkt,
    output logic                 alu_ack,
    // Branch issue port
    input  logic                 br_req,
    input  exec_pkg::br_issue_t  br_pkt,
    output logic                 br_ack,
    // Completion port to the ROB
    output logic                 complete_req,
    output exec_pkg::complete_t  complete_pkt,
    input  logic                 complete_ack
);

    // Result slots between the units and the merger
    exec_pkg::complete_t alu_res;
    exec_pkg::complete_t br_res;
    logic                alu_full;
    logic                br_full;
    logic                alu_take;
    logic                br_take;

    // =========================================================================
    // Functional units
    // =========================================================================

    alu_unit alu_unit_i (
        .clock    (clock),
        .arst_n   (arst_n),
        .alu_req  (alu_req),
        .alu_pkt  (alu_pkt),
        .alu_ack  (alu_ack),
        .alu_take (alu_take),
        .alu_full (alu_full),
        .alu_res  (alu_res)
    );

    branch_unit branch_unit_i (
        .clock   (clock),
        .arst_n  (arst_n),
        .br_req  (br_req),
        .br_pkt  (br_pkt),
        .br_ack  (br_ack),
        .br_take (br_take),
        .br_full (br_full),
        .br_res  (br_res)
    );

    // Completion merger where the branch wins ties
    complete_merge complete_merge_i (
        .clock        (clock),
        .arst_n       (arst_n),
        .alu_full     (alu_full),
        .alu_res      (alu_res),
        .br_full      (br_full),
        .br_res       (br_res),
        .alu_take     (alu_take),
        .br_take      (br_take),
        .complete_req (complete_req),
        .complete_pkt (complete_pkt),
        .complete_ack (complete_ack)
    );

endmodule

/* sim/exec_ref.svh */
`ifndef EXEC_REF_SVH
`define EXEC_REF_SVH

// ============================================================================
// Expected completions built from the ISA rules of each unit
// ============================================================================

// ALU result for one issue packet
function automatic exec_pkg::complete_t alu_expect(input exec_pkg::alu_issue_t p);
    logic [31:0]         a;
    logic [31:0]         b;
    exec_pkg::complete_t c;
    case (p.opa_sel)
        exec_pkg::OPA_RS1: a = p.rs1;
        exec_pkg::OPA_PC:  a = p.pc;
        exec_pkg::OPA_NPC: a = p.pc + 32'd4;
        default:           a = 32'd0;
    endcase
    b = (p.opb_sel == exec_pkg::OPB_IMM) ? p.imm : p.rs2;
    // Branch fields stay zero for ALU work
    c = '0;
    c.rob_idx     = p.rob_idx;
    c.dest_pr     = p.dest_pr;
    c.write_valid = (p.dest_pr != 6'd0);
    case (p.func)
        exec_pkg::ADD:  c.result = a + b;
        exec_pkg::SUB:  c.result = a - b;
        exec_pkg::AND:  c.result = a & b;
        exec_pkg::OR:   c.result = a | b;
        exec_pkg::XOR:  c.result = a ^ b;
        exec_pkg::SLT:  c.result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        exec_pkg::SLTU: c.result = (a < b) ? 32'd1 : 32'd0;
        // Shift amount is b[4:0]
        exec_pkg::SLL:  c.result = a << b[4:0];
        exec_pkg::SRL:  c.result = a >> b[4:0];
        exec_pkg::SRA:  c.result = $unsigned($signed(a) >>> b[4:0]);
        default:        c.result = 32'd0;
    endcase
    return c;
endfunction

// Branch result for one issue packet
function automatic exec_pkg::complete_t branch_expect(input exec_pkg::br_issue_t p);
    logic                taken;
    logic                jump;
    exec_pkg::complete_t c;
    jump = (p.func == exec_pkg::JAL) || (p.func == exec_pkg::JALR);
    case (p.func)
        exec_pkg::BEQ:  taken = (p.rs1 == p.rs2);
        exec_pkg::BNE:  taken = (p.rs1 != p.rs2);
        exec_pkg::BLT:  taken = ($signed(p.rs1) < $signed(p.rs2));
        exec_pkg::BGE:  taken = !($signed(p.rs1) < $signed(p.rs2));
        exec_pkg::BLTU: taken = (p.rs1 < p.rs2);
        exec_pkg::BGEU: taken = !(p.rs1 < p.rs2);
        default:        taken = 1'b1;
    endcase
    c.rob_idx       = p.rob_idx;
    c.dest_pr       = p.dest_pr;
    c.write_valid   = jump && (p.dest_pr != 6'd0);
    // Link value
    c.result        = p.pc + 32'd4;
    c.branch_valid  = 1'b1;
    c.branch_taken  = taken;
    c.branch_target = (p.func == exec_pkg::JALR) ? ((p.rs1 + p.offset) & 32'hffff_fffe)
                                                 : (p.pc + p.offset);
    c.mispredict    = taken ^ p.pred_taken;
    return c;
endfunction

`endif

/* sim/exec_stage_tb.sv */
`timescale 1ns/100ps

module exec_stage_tb;

    // Operation counts per test
    localparam int N_ALU          = 80;
    localparam int N_BR           = 32;
    localparam int N_PAIR         = 4;
    localparam int N_BP           = 6;
    localparam int N_OPS          = N_ALU + N_BR + 2 * N_PAIR + 2 * N_BP;
    localparam int TIMEOUT_CYCLES = 40 * N_OPS + 200;

    logic                 clock;
    logic                 arst_n;
    logic                 alu_req;
    exec_pkg::alu_issue_t alu_pkt;
    logic                 alu_ack;
    logic                 br_req;
    exec_pkg::br_issue_t  br_pkt;
    logic                 br_ack;
    logic                 complete_req;
    exec_pkg::complete_t  complete_pkt;
    logic                 complete_ack;

    // Expected completions in issue order with one queue per unit
    exec_pkg::complete_t  alu_exp_q[$];
    exec_pkg::complete_t  br_exp_q[$];
    // branch_valid of each completion in arrival order
    logic                 order_q[$];

    int alu_issued;
    int br_issued;
    int alu_done;
    int br_done;
    int ack_delay;
    int checks;
    int errors;
    int cycle_count;

    `include "exec_ref.svh"

    exec_stage exec_stage_i (
        .clock        (clock),
        .arst_n       (arst_n),
        .alu_req      (alu_req),
        .alu_pkt      (alu_pkt),
        .alu_ack      (alu_ack),
        .br_req       (br_req),
        .br_pkt       (br_pkt),
        .br_ack       (br_ack),
        .complete_req (complete_req),
        .complete_pkt (complete_pkt),
        .complete_ack (complete_ack)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    // ========================================================================
    // Checks and stimulus helpers
    // ========================================================================

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        assert (got === expected) else begin
            $display("FAIL %s got %h expected %h", name, got, expected);
            errors++;
        end
    endtask

    task automatic compare_completion(input exec_pkg::complete_t got,
                                      input exec_pkg::complete_t expected);
        check_field("rob_idx", 32'(got.rob_idx), 32'(expected.rob_idx));
        check_field("dest_pr", 32'(got.dest_pr), 32'(expected.dest_pr));
        check_field("write_valid", 32'(got.write_valid), 32'(expected.write_valid));
        check_field("result", got.result, expected.result);
        check_field("branch_valid", 32'(got.branch_valid), 32'(expected.branch_valid));
        check_field("branch_taken", 32'(got.branch_taken), 32'(expected.branch_taken));
        check_field("branch_target", got.branch_target, expected.branch_target);
        check_field("mispredict", 32'(got.mispredict), 32'(expected.mispredict));
    endtask

    function automatic exec_pkg::alu_issue_t random_alu_pkt(input int f, input int a,
                                                            input int b);
        exec_pkg::alu_issue_t p;
        p.rob_idx = 5'($urandom);
        // Every fourth op or so has no destination
        p.dest_pr = ($urandom % 4 == 0) ? 6'd0 : 6'($urandom);
        p.pc      = $urandom & 32'hffff_fffc;
        p.rs1     = $urandom;
        p.rs2     = $urandom;
        p.imm     = $urandom;
        p.func    = exec_pkg::alu_op_e'(f);
        p.opa_sel = exec_pkg::opa_sel_e'(a);
        p.opb_sel = exec_pkg::opb_sel_e'(b);
        return p;
    endfunction

    function automatic exec_pkg::br_issue_t random_branch_pkt(input int f);
        exec_pkg::br_issue_t p;
        p.rob_idx    = 5'($urandom);
        p.dest_pr    = ($urandom % 4 == 0) ? 6'd0 : 6'($urandom);
        p.pc         = $urandom & 32'hffff_fffc;
        p.rs1        = $urandom;
        // Equal operands half the time so BEQ and BNE go both ways
        p.rs2        = ($urandom % 2 == 0) ? p.rs1 : $urandom;
        p.offset     = $urandom;
        p.func       = exec_pkg::br_op_e'(f);
        p.pred_taken = 1'($urandom);
        return p;
    endfunction

    // Four-phase issue that returns once ack is low again
    task automatic issue_alu(input exec_pkg::alu_issue_t p);
        @(negedge clock);
        alu_pkt = p;
        alu_req = 1'b1;
        alu_exp_q.push_back(alu_expect(p));
        alu_issued++;
        @(negedge clock);
        while (!alu_ack) @(negedge clock);
        alu_req = 1'b0;
        @(negedge clock);
        while (alu_ack) @(negedge clock);
    endtask

    task automatic issue_branch(input exec_pkg::br_issue_t p);
        @(negedge clock);
        br_pkt = p;
        br_req = 1'b1;
        br_exp_q.push_back(branch_expect(p));
        br_issued++;
        @(negedge clock);
        while (!br_ack) @(negedge clock);
        br_req = 1'b0;
        @(negedge clock);
        while (br_ack) @(negedge clock);
    endtask

    // ROB side of the completion port that compares each packet on arrival
    task automatic respond_complete();
        exec_pkg::complete_t held;
        int                  n;
        forever begin
            @(negedge clock);
            if (complete_req && !complete_ack) begin
                held = complete_pkt;
                order_q.push_back(held.branch_valid);
                if (held.branch_valid) begin
                    br_done++;
                    assert (br_exp_q.size() != 0) begin
                        compare_completion(held, br_exp_q.pop_front());
                    end else begin
                        $display("Branch completion arrived with none outstanding");
                        errors++;
                    end
                end else begin
                    alu_done++;
                    assert (alu_exp_q.size() != 0) begin
                        compare_completion(held, alu_exp_q.pop_front());
                    end else begin
                        $display("ALU completion arrived with none outstanding");
                        errors++;
                    end
                end
                // Packet must hold under back-pressure
                for (n = 0; n < ack_delay; n++) begin
                    @(negedge clock);
                    check_field("complete_req", 32'(complete_req), 32'd1);
                    checks++;
                    assert (complete_pkt === held) else begin
                        $display("FAIL complete_pkt got %h expected %h", complete_pkt, held);
                        errors++;
                    end
                end
                complete_ack = 1'b1;
                @(negedge clock);
                while (complete_req) @(negedge clock);
                complete_ack = 1'b0;
            end
        end
    endtask

    // An issue ack may only rise onto an empty slot
    task automatic watch_issue_acks();
        logic alu_ack_d;
        logic br_ack_d;
        logic alu_full_d;
        logic br_full_d;
        alu_ack_d  = 1'b0;
        br_ack_d   = 1'b0;
        alu_full_d = 1'b0;
        br_full_d  = 1'b0;
        forever begin
            @(negedge clock);
            assert (!(alu_ack && !alu_ack_d && alu_full_d)) else begin
                $display("alu_ack rose while the ALU slot was still full");
                errors++;
            end
            assert (!(br_ack && !br_ack_d && br_full_d)) else begin
                $display("br_ack rose while the branch slot was still full");
                errors++;
            end
            alu_ack_d  = alu_ack;
            br_ack_d   = br_ack;
            alu_full_d = exec_stage_i.alu_full;
            br_full_d  = exec_stage_i.br_full;
        end
    endtask

    task automatic watch_timeout();
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("Timeout after %0d cycles with completions still missing", cycle_count);
        $display("** FAIL **");
        $finish;
    endtask

    // Block until every issued op has shown up on the completion port
    task automatic wait_drain();
        while (alu_done + br_done != alu_issued + br_issued) @(negedge clock);
        @(negedge clock);
    endtask

    task automatic report_test(input int num, input string name, input int errors_before);
        $display("test %0d %s: %0d errors", num, name, errors - errors_before);
    endtask

    // ========================================================================
    // Test sequence
    // ========================================================================

    initial begin
        int f;
        int a;
        int b;
        int k;
        int e0;
        arst_n       = 1'b0;
        alu_req      = 1'b0;
        alu_pkt      = '0;
        br_req       = 1'b0;
        br_pkt       = '0;
        complete_ack = 1'b0;
        ack_delay    = 0;
        void'($urandom(96));
        fork
            respond_complete();
            watch_issue_acks();
            watch_timeout();
        join_none
        repeat (3) @(negedge clock);
        arst_n = 1'b1;

        // Idle outputs after reset
        e0 = errors;
        @(negedge clock);
        check_field("alu_ack", 32'(alu_ack), 32'd0);
        check_field("br_ack", 32'(br_ack), 32'd0);
        check_field("complete_req", 32'(complete_req), 32'd0);
        report_test(1, "reset", e0);

        // Every ALU op with every operand source
        e0 = errors;
        for (f = 0; f < 10; f++) begin
            for (a = 0; a < 4; a++) begin
                for (b = 0; b < 2; b++) begin
                    issue_alu(random_alu_pkt(f, a, b));
                end
            end
        end
        wait_drain();
        report_test(2, "alu operations", e0);

        // All branch ops with a one-cycle ack delay
        e0 = errors;
        ack_delay = 1;
        for (f = 0; f < 8; f++) begin
            repeat (N_BR / 8) issue_branch(random_branch_pkt(f));
        end
        wait_drain();
        report_test(3, "branch operations", e0);

        // Same-cycle issue into empty slots where the branch must drain first
        e0 = errors;
        ack_delay = 0;
        order_q.delete();
        for (k = 0; k < N_PAIR; k++) begin
            fork
                issue_alu(random_alu_pkt(int'($urandom % 10), int'($urandom % 4),
                                         int'($urandom % 2)));
                issue_branch(random_branch_pkt(int'($urandom % 8)));
            join
            wait_drain();
        end
        check_field("completion count", order_q.size(), 2 * N_PAIR);
        for (k = 0; k < order_q.size(); k++) begin
            check_field("branch_valid order", 32'(order_q[k]), (k % 2 == 0) ? 32'd1 : 32'd0);
        end
        report_test(4, "both units together", e0);

        // Long ack delay while both issuers keep pushing
        e0 = errors;
        ack_delay = 15;
        fork
            begin
                repeat (N_BP) issue_alu(random_alu_pkt(int'($urandom % 10),
                                                       int'($urandom % 4),
                                                       int'($urandom % 2)));
            end
            begin
                repeat (N_BP) issue_branch(random_branch_pkt(int'($urandom % 8)));
            end
        join
        wait_drain();
        check_field("alu completions", alu_done, alu_issued);
        check_field("branch completions", br_done, br_issued);
        report_test(5, "back-pressure", e0);

        $display("checks %0d, errors %0d, ops %0d", checks, errors, alu_issued + br_issued);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* list.f */
+incdir+sim
src/exec_pkg.sv
src/alu_unit.sv
src/branch_unit.sv
src/complete_merge.sv
src/exec_stage.sv
sim/exec_stage_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the execute stage testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -j 0 \
    --top-module exec_stage_tb -f list.f -o exec_stage_sim
./obj_dir/exec_stage_sim | tee sim.log

# Pass only if the testbench printed the pass line
grep -q '^\*\* PASS \*\*$' sim.log
